/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_core
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulator exits non-zero when the testbench stops with $fatal
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
+incdir+include
rtl/core_pkg.sv
rtl/fetch_unit.sv
rtl/execute_unit.sv
rtl/xram_write_port.sv
rtl/core.sv
testbench/tb_memories.sv
testbench/tb_core.sv

/* include/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

//////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////

`define CORE_DATA_W      8          // one data byte
`define CORE_ADDR_W      16         // code and xdata space

//////////////////////////////////////////////////
// register bank
//////////////////////////////////////////////////

`define CORE_NUM_REGS    8          // R0 to R7 in a single bank
`define CORE_REG_IDX_W   3          // index into the bank

//////////////////////////////////////////////////
// reset values
//////////////////////////////////////////////////

`define CORE_ACC_RESET   8'h00
`define CORE_DPTR_RESET  16'h0000

`endif

/* rtl/core.sv */
`timescale 1ns/1ps

module core (
    input  logic            clk,
    input  logic            rst,
    output core_pkg::addr_t rom_addr,
    input  core_pkg::byte_t rom_data,
    output logic            ram_wr_en,
    output core_pkg::addr_t ram_wr_addr,
    output core_pkg::byte_t ram_wr_data
);
    import core_pkg::*;

    instr_t    instr;
    logic      issue;
    redirect_t redirect;
    store_t    store;

    fetch_unit u_fetch (
        .clk      (clk),
        .rst      (rst),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .redirect (redirect),
        .instr    (instr),
        .issue    (issue)
    );

    execute_unit u_execute (
        .clk      (clk),
        .rst      (rst),
        .instr    (instr),
        .issue    (issue),
        .redirect (redirect),
        .store    (store)
    );

    xram_write_port u_xram_wr (
        .clk         (clk),
        .rst         (rst),
        .store       (store),
        .ram_wr_en   (ram_wr_en),
        .ram_wr_addr (ram_wr_addr),
        .ram_wr_data (ram_wr_data)
    );

endmodule

/* rtl/core_pkg.sv */
`include "core_consts.svh"

package core_pkg;

    typedef logic [`CORE_DATA_W-1:0] byte_t;
    typedef logic [`CORE_ADDR_W-1:0] addr_t;

    // standard 8051 encodings with the register forms at their base value
    typedef enum logic [7:0] {
        op_nop         = 8'h00,
        op_inc_a       = 8'h04,
        op_add_imm     = 8'h24,
        op_orl_imm     = 8'h44,
        op_anl_imm     = 8'h54,
        op_jz          = 8'h60,
        op_xrl_imm     = 8'h64,
        op_jnz         = 8'h70,
        op_mov_imm     = 8'h74,
        op_sjmp        = 8'h80,
        op_mov_dptr    = 8'h90,
        op_inc_dptr    = 8'hA3,
        op_clr_a       = 8'hE4,
        op_mov_a_rn    = 8'hE8,
        op_movx_dptr_a = 8'hF0,
        op_movx_ri_a   = 8'hF2,
        op_cpl_a       = 8'hF4,
        op_mov_rn_a    = 8'hF8
    } opcode_e;

    typedef enum logic [4:0] {
        cls_nop, cls_mov_imm, cls_add_imm, cls_anl_imm, cls_orl_imm, cls_xrl_imm,
        cls_inc_acc, cls_clr_acc, cls_cpl_acc, cls_mov_dptr, cls_inc_dptr,
        cls_movx_dptr, cls_movx_ri, cls_mov_reg_acc, cls_mov_acc_reg,
        cls_sjmp, cls_jz, cls_jnz
    } op_class_e;

    typedef enum logic [1:0] {
        fs_opcode,
        fs_operand1,
        fs_operand2,
        fs_issue
    } fetch_state_e;

    typedef enum logic {
        xm_dptr,
        xm_ri
    } xram_mode_e;

    typedef struct packed {
        byte_t opcode;
        byte_t operand1;
        byte_t operand2;
        addr_t next_pc;                 // address right after the last byte
    } instr_t;

    typedef struct packed {
        logic  taken;
        addr_t target;
    } redirect_t;

    typedef struct packed {
        logic       req;
        xram_mode_e mode;
        addr_t      dptr;
        byte_t      ri;
        byte_t      acc;
    } store_t;

    function automatic op_class_e decode_class(input byte_t op);
        op_class_e cls;
        case (op)
            op_nop:         cls = cls_nop;
            op_mov_imm:     cls = cls_mov_imm;
            op_add_imm:     cls = cls_add_imm;
            op_anl_imm:     cls = cls_anl_imm;
            op_orl_imm:     cls = cls_orl_imm;
            op_xrl_imm:     cls = cls_xrl_imm;
            op_inc_a:       cls = cls_inc_acc;
            op_clr_a:       cls = cls_clr_acc;
            op_cpl_a:       cls = cls_cpl_acc;
            op_mov_dptr:    cls = cls_mov_dptr;
            op_inc_dptr:    cls = cls_inc_dptr;
            op_movx_dptr_a: cls = cls_movx_dptr;
            op_sjmp:        cls = cls_sjmp;
            op_jz:          cls = cls_jz;
            op_jnz:         cls = cls_jnz;
            default:        cls = cls_nop;
        endcase
        // register forms carry the register number in the low bits
        if ((op & 8'hF8) == op_mov_rn_a)  cls = cls_mov_reg_acc;
        if ((op & 8'hF8) == op_mov_a_rn)  cls = cls_mov_acc_reg;
        if ((op & 8'hFE) == op_movx_ri_a) cls = cls_movx_ri;
        return cls;
    endfunction

    function automatic logic [1:0] instr_length(input byte_t op);
        logic [1:0] len;
        case (decode_class(op))
            cls_mov_dptr: len = 2'd3;
            cls_mov_imm, cls_add_imm, cls_anl_imm, cls_orl_imm, cls_xrl_imm,
            cls_sjmp, cls_jz, cls_jnz: len = 2'd2;
            default:      len = 2'd1;
        endcase
        return len;
    endfunction

endpackage

/* rtl/execute_unit.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module execute_unit (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::instr_t    instr,
    input  logic                issue,
    output core_pkg::redirect_t redirect,
    output core_pkg::store_t    store
);
    import core_pkg::*;

    op_class_e                       cls;
    byte_t                           acc;
    addr_t                           dptr;
    byte_t [`CORE_NUM_REGS-1:0]      regs;
    logic  [`CORE_REG_IDX_W-1:0]     rn;
    logic  [`CORE_REG_IDX_W-1:0]     ri_idx;
    addr_t                           rel_target;
    logic                            take_branch;

    assign cls    = decode_class(instr.opcode);
    assign rn     = instr.opcode[`CORE_REG_IDX_W-1:0];
    assign ri_idx = {{(`CORE_REG_IDX_W-1){1'b0}}, instr.opcode[0]};   // only R0 and R1 point

    // relative offset is signed and counts from the following instruction
    assign rel_target = instr.next_pc + addr_t'(signed'(instr.operand1));

    //////////////////////////////////////////////////
    // branch resolution and store request
    //////////////////////////////////////////////////

    always_comb begin
        case (cls)
            cls_sjmp: take_branch = 1'b1;
            cls_jz:   take_branch = (acc == '0);
            cls_jnz:  take_branch = (acc != '0);
            default:  take_branch = 1'b0;
        endcase
    end

    always_comb begin
        redirect.taken  = issue && take_branch;
        redirect.target = rel_target;
    end

    always_comb begin
        store.req  = issue && ((cls == cls_movx_dptr) || (cls == cls_movx_ri));
        store.mode = (cls == cls_movx_ri) ? xm_ri : xm_dptr;
        store.dptr = dptr;
        store.ri   = regs[ri_idx];
        store.acc  = acc;
    end

    //////////////////////////////////////////////////
    // architectural state
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            acc  <= `CORE_ACC_RESET;
            dptr <= `CORE_DPTR_RESET;
            regs <= '0;
        end else if (issue) begin
            case (cls)
                cls_mov_imm:     acc <= instr.operand1;
                cls_add_imm:     acc <= acc + instr.operand1;        // no carry kept
                cls_anl_imm:     acc <= acc & instr.operand1;
                cls_orl_imm:     acc <= acc | instr.operand1;
                cls_xrl_imm:     acc <= acc ^ instr.operand1;
                cls_inc_acc:     acc <= acc + 1'b1;
                cls_clr_acc:     acc <= '0;
                cls_cpl_acc:     acc <= ~acc;
                cls_mov_dptr:    dptr <= {instr.operand1, instr.operand2};  // high byte first
                cls_inc_dptr:    dptr <= dptr + 1'b1;
                cls_mov_reg_acc: regs[rn] <= acc;
                cls_mov_acc_reg: acc <= regs[rn];
                default: begin
                end
            endcase
        end
    end

    // a taken branch must hand fetch a usable target
    assert property (@(posedge clk) disable iff (!rst)
        redirect.taken |-> !$isunknown(redirect.target));

endmodule

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                clk,
    input  logic                rst,
    output core_pkg::addr_t     rom_addr,
    input  core_pkg::byte_t     rom_data,
    input  core_pkg::redirect_t redirect,
    output core_pkg::instr_t    instr,
    output logic                issue
);
    import core_pkg::*;

    fetch_state_e state;
    addr_t        pc;
    logic         flush;                // rom_data holds no requested byte this cycle
    byte_t        op_q;
    byte_t        opr1_q;
    byte_t        cur_op;
    logic [1:0]   cur_len;
    logic         last_byte;
    instr_t       instr_d;

    assign rom_addr = pc;
    assign issue    = (state == fs_issue);

    assign cur_op  = (state == fs_opcode) ? rom_data : op_q;
    assign cur_len = instr_length(cur_op);

    always_comb begin
        case (state)
            fs_opcode:   last_byte = !flush && (cur_len == 2'd1);
            fs_operand1: last_byte = (cur_len == 2'd2);
            fs_operand2: last_byte = 1'b1;
            default:     last_byte = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // instruction assembly
    //////////////////////////////////////////////////

    always_comb begin
        instr_d.opcode  = cur_op;
        instr_d.next_pc = pc;           // pc runs one ahead of the byte on rom_data
        case (state)
            fs_operand1: begin
                instr_d.operand1 = rom_data;
                instr_d.operand2 = '0;
            end
            fs_operand2: begin
                instr_d.operand1 = opr1_q;
                instr_d.operand2 = rom_data;
            end
            default: begin
                instr_d.operand1 = '0;
                instr_d.operand2 = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == fs_opcode) op_q <= rom_data;
        if (state == fs_operand1) opr1_q <= rom_data;
        if (last_byte) instr <= instr_d;
    end

    //////////////////////////////////////////////////
    // fetch FSM and program counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= fs_opcode;
            pc    <= '0;
            flush <= 1'b1;
        end else begin
            flush <= 1'b0;
            case (state)
                fs_opcode: begin
                    if (!last_byte) pc <= pc + 1'b1;     // hold pc on the next opcode address
                    if (!flush) state <= last_byte ? fs_issue : fs_operand1;
                end
                fs_operand1: begin
                    if (!last_byte) pc <= pc + 1'b1;
                    state <= last_byte ? fs_issue : fs_operand2;
                end
                fs_operand2: state <= fs_issue;
                default: begin
                    state <= fs_opcode;
                    if (redirect.taken) begin
                        pc    <= redirect.target;
                        flush <= 1'b1;                   // byte for the old pc is still coming
                    end else begin
                        pc <= pc + 1'b1;
                    end
                end
            endcase
        end
    end

    // an issued instruction is built only from known ROM bytes
    assert property (@(posedge clk) disable iff (!rst) issue |-> !$isunknown(instr));

endmodule

/* rtl/xram_write_port.sv */
`timescale 1ns/1ps

module xram_write_port (
    input  logic             clk,
    input  logic             rst,
    input  core_pkg::store_t store,
    output logic             ram_wr_en,
    output core_pkg::addr_t  ram_wr_addr,
    output core_pkg::byte_t  ram_wr_data
);
    import core_pkg::*;

    addr_t wr_addr;

    // @Ri reaches only the low 256 bytes of xdata
    assign wr_addr = (store.mode == xm_ri) ? addr_t'(store.ri) : store.dptr;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ram_wr_en <= 1'b0;
        end else begin
            ram_wr_en <= store.req;
        end
    end

    always_ff @(posedge clk) begin
        if (store.req) begin
            ram_wr_addr <= wr_addr;
            ram_wr_data <= store.acc;
        end
    end

    assert property (@(posedge clk) disable iff (!rst) ram_wr_en |-> !$isunknown(ram_wr_addr));

endmodule

/* testbench/tb_core.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module tb_core;
    import core_pkg::*;

    localparam int WRITE_TIMEOUT = 200;           // cycles allowed until the next store
    localparam int QUIET_CYCLES  = 24;
    localparam int RESET_CYCLES  = 16;

    logic        clk;
    logic        rst;
    addr_t       rom_addr;
    byte_t       rom_data;
    logic        ram_wr_en;
    addr_t       ram_wr_addr;
    byte_t       ram_wr_data;
    logic [7:0]  write_count;
    logic [7:0]  write_base;
    logic [15:0] lfsr;

    byte_t prog [$];
    addr_t exp_addr [$];
    byte_t exp_data [$];
    byte_t m_acc;
    addr_t m_dptr;
    byte_t m_regs [0:`CORE_NUM_REGS-1];
    logic  live;                                  // low while emitting bytes a branch skips

    core dut0 (
        .clk         (clk),
        .rst         (rst),
        .rom_addr    (rom_addr),
        .rom_data    (rom_data),
        .ram_wr_en   (ram_wr_en),
        .ram_wr_addr (ram_wr_addr),
        .ram_wr_data (ram_wr_data)
    );

    tb_rom rom0 (
        .clk  (clk),
        .addr (rom_addr),
        .data (rom_data)
    );

    tb_xram_monitor mon0 (
        .clk     (clk),
        .wr_en   (ram_wr_en),
        .wr_addr (ram_wr_addr),
        .wr_data (ram_wr_data),
        .count   (write_count)
    );

    always #2 clk = ~clk;

    //////////////////////////////////////////////////
    // failure reporting and compares
    //////////////////////////////////////////////////

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_addr(input string what, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_byte(input string what, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %b, got %b", $time, what, expected, actual);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////
    // random bytes
    //////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16 + x^14 + x^13 + x^11 + 1
    endfunction

    task automatic random_byte(output byte_t b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b    = {b[6:0], lfsr[0]};
        end
    endtask

    task automatic random_addr(output addr_t a);
        byte_t hi;
        byte_t lo;
        random_byte(hi);
        random_byte(lo);
        a = {hi, lo};
    endtask

    //////////////////////////////////////////////////
    // program builders with a reference model
    //////////////////////////////////////////////////

    task automatic start_program();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        m_acc  = `CORE_ACC_RESET;
        m_dptr = `CORE_DPTR_RESET;
        live   = 1'b1;
        for (int n = 0; n < `CORE_NUM_REGS; n++) begin
            m_regs[n] = '0;
        end
    endtask

    task automatic expect_write(input addr_t a, input byte_t d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    task automatic put_mov_dptr(input addr_t a);
        prog.push_back(op_mov_dptr);
        prog.push_back(a[15:8]);                  // high byte comes first
        prog.push_back(a[7:0]);
        if (live) m_dptr = a;
    endtask

    task automatic put_acc_imm(input opcode_e op, input byte_t x);
        prog.push_back(op);
        prog.push_back(x);
        if (live) begin
            case (op)
                op_mov_imm: m_acc = x;
                op_add_imm: m_acc = m_acc + x;    // carry is dropped
                op_anl_imm: m_acc = m_acc & x;
                op_orl_imm: m_acc = m_acc | x;
                default:    m_acc = m_acc ^ x;
            endcase
        end
    endtask

    task automatic put_single(input opcode_e op);
        prog.push_back(op);
        if (live) begin
            case (op)
                op_inc_a:       m_acc = m_acc + 8'd1;
                op_clr_a:       m_acc = '0;
                op_cpl_a:       m_acc = ~m_acc;
                op_inc_dptr:    m_dptr = m_dptr + 16'd1;
                op_movx_dptr_a: expect_write(m_dptr, m_acc);
                default: begin
                end
            endcase
        end
    endtask

    task automatic put_reg(input opcode_e op, input int n);
        prog.push_back(op | byte_t'(n));
        if (live) begin
            case (op)
                op_mov_rn_a: m_regs[n] = m_acc;
                op_mov_a_rn: m_acc = m_regs[n];
                default:     expect_write({8'h00, m_regs[n]}, m_acc);
            endcase
        end
    endtask

    task automatic put_branch(input opcode_e op, input byte_t rel);
        logic taken;
        prog.push_back(op);
        prog.push_back(rel);
        case (op)
            op_jz:   taken = (m_acc == '0);
            op_jnz:  taken = (m_acc != '0);
            default: taken = 1'b1;
        endcase
        if (live) live = !taken;
    endtask

    // two bytes right behind a branch with offset 2
    task automatic put_shadow_store();
        put_single(op_inc_dptr);
        put_single(op_movx_dptr_a);
        live = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // run control
    //////////////////////////////////////////////////

    task automatic load_and_reset();
        write_base = write_count;
        @(posedge clk);
        rst <= 1'b0;
        for (int a = 0; a < 256; a++) begin
            rom0.mem[a] = op_nop;
        end
        for (int a = 0; a < prog.size(); a++) begin
            rom0.mem[a] = prog[a];
        end
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
            compare_flag("ram_wr_en during reset", 1'b0, ram_wr_en);
        end
        rst <= 1'b1;
    endtask

    task automatic wait_for_write(input logic [7:0] idx);
        int cycles;
        cycles = 0;
        while (write_count == idx) begin
            @(posedge clk);
            cycles++;
            if (cycles > WRITE_TIMEOUT) begin
                $display("Timeout: no external RAM write within %0d cycles", WRITE_TIMEOUT);
                abort_run();
            end
        end
    endtask

    task automatic check_writes();
        logic [7:0] idx;
        idx = write_base;
        for (int k = 0; k < exp_addr.size(); k++) begin
            wait_for_write(idx);
            compare_addr("write address", exp_addr[k], mon0.addr_log[idx]);
            compare_byte("write data", exp_data[k], mon0.data_log[idx]);
            idx++;
        end
        repeat (QUIET_CYCLES) @(posedge clk);
        if (write_count != idx) begin
            $display("More external RAM writes than the program should make");
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic test_reset_and_nops();
        addr_t prev;
        start_program();                          // empty program leaves the ROM all NOPs
        load_and_reset();
        @(negedge clk);
        compare_addr("rom_addr after reset", '0, rom_addr);
        prev = rom_addr;
        for (int c = 0; c < 60; c++) begin
            @(negedge clk);
            compare_flag("ram_wr_en during NOPs", 1'b0, ram_wr_en);
            if (rom_addr < prev) begin
                $display("Error at %0t ns: rom_addr fell from %h to %h", $time, prev, rom_addr);
                abort_run();
            end
            prev = rom_addr;
        end
        if (prev < 16'd20) begin
            $display("Error at %0t ns: rom_addr only reached %h", $time, prev);
            abort_run();
        end
    endtask

    task automatic test_immediate_alu();
        opcode_e ops [0:4];
        addr_t   d;
        byte_t   x;
        ops = '{op_mov_imm, op_add_imm, op_anl_imm, op_orl_imm, op_xrl_imm};
        start_program();
        random_addr(d);
        put_mov_dptr(d);
        for (int k = 0; k < 5; k++) begin
            random_byte(x);
            put_acc_imm(ops[k], x);
            put_single(op_movx_dptr_a);
        end
        put_branch(op_sjmp, 8'hFE);               // park on itself
        load_and_reset();
        check_writes();
    endtask

    task automatic test_acc_and_dptr();
        opcode_e ops [0:2];
        addr_t   d;
        byte_t   x;
        ops = '{op_inc_a, op_cpl_a, op_clr_a};
        start_program();
        random_addr(d);
        random_byte(x);
        put_mov_dptr(d);
        put_acc_imm(op_mov_imm, x);
        for (int k = 0; k < 3; k++) begin
            put_single(ops[k]);
            put_single(op_inc_dptr);
            put_single(op_movx_dptr_a);
        end
        put_branch(op_sjmp, 8'hFE);
        load_and_reset();
        check_writes();
    endtask

    task automatic test_register_bank();
        addr_t d;
        byte_t v;
        start_program();
        for (int n = 0; n < `CORE_NUM_REGS; n++) begin
            random_byte(v);
            put_acc_imm(op_mov_imm, v);
            put_reg(op_mov_rn_a, n);
        end
        random_addr(d);
        put_mov_dptr(d);
        for (int k = 0; k < `CORE_NUM_REGS; k++) begin
            put_reg(op_mov_a_rn, (k * 5 + 3) % `CORE_NUM_REGS);    // visits every register once
            put_single(op_movx_dptr_a);
            put_single(op_inc_dptr);
        end
        put_reg(op_movx_ri_a, 0);
        put_reg(op_movx_ri_a, 1);
        put_branch(op_sjmp, 8'hFE);
        load_and_reset();
        check_writes();
    endtask

    task automatic test_branches();
        addr_t d;
        byte_t x;
        start_program();
        random_addr(d);
        random_byte(x);
        put_mov_dptr(d);
        put_acc_imm(op_mov_imm, x | 8'h01);
        put_single(op_movx_dptr_a);
        put_branch(op_sjmp, 8'd2);
        put_shadow_store();
        put_single(op_inc_dptr);
        put_single(op_movx_dptr_a);
        put_single(op_clr_a);
        put_branch(op_jz, 8'd2);                  // taken
        put_shadow_store();
        put_single(op_movx_dptr_a);
        put_branch(op_jnz, 8'd2);                 // not taken
        put_shadow_store();
        random_byte(x);
        put_acc_imm(op_mov_imm, x | 8'h80);
        put_branch(op_jz, 8'd2);                  // not taken
        put_shadow_store();
        put_branch(op_jnz, 8'd2);                 // taken
        put_shadow_store();
        put_single(op_movx_dptr_a);
        put_branch(op_sjmp, 8'hFE);
        load_and_reset();
        check_writes();
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b0;
        lfsr       = 16'd26;
        write_base = '0;
        test_reset_and_nops();
        test_immediate_alu();
        test_acc_and_dptr();
        test_register_bank();
        test_branches();
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* testbench/tb_memories.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

// program ROM with one cycle from address to data
module tb_rom (
    input  logic                    clk,
    input  logic [`CORE_ADDR_W-1:0] addr,
    output logic [`CORE_DATA_W-1:0] data
);
    logic [`CORE_DATA_W-1:0] mem [0:255];        // loaded by the tests
    logic [`CORE_DATA_W-1:0] data_q = '0;

    assign data = data_q;

    always @(posedge clk) begin
        data_q <= mem[addr[7:0]];                 // test programs stay in the low 256 bytes
    end
endmodule

// logs every external RAM write strobe in arrival order
module tb_xram_monitor (
    input  logic                    clk,
    input  logic                    wr_en,
    input  logic [`CORE_ADDR_W-1:0] wr_addr,
    input  logic [`CORE_DATA_W-1:0] wr_data,
    output logic [7:0]              count
);
    logic [`CORE_ADDR_W-1:0] addr_log [0:255];
    logic [`CORE_DATA_W-1:0] data_log [0:255];
    logic [7:0]              count_q = '0;

    assign count = count_q;

    always @(posedge clk) begin
        if (wr_en) begin
            addr_log[count_q] <= wr_addr;
            data_log[count_q] <= wr_data;
            count_q           <= count_q + 8'd1;  // strobes during reset are logged as well
        end
    end
endmodule
